//--- logic/alu_data_pkg.sv
package alu_data_pkg;

    // architectural register width
    localparam int XLEN = 32;

    // the two architectural halves of the HI/LO pair
    typedef struct packed {
        logic [XLEN-1:0] hi;
        logic [XLEN-1:0] lo;
    } hilo_half_t;

    // full product or accumulator seen as one word, or as HI and LO
    typedef union packed {
        logic [2*XLEN-1:0] full;
        hilo_half_t        half;
    } hilo_word_u;

    // write request towards the HI/LO register
    typedef struct packed {
        logic       hi_we;
        logic       lo_we;
        hilo_word_u data;
    } hilo_wr_t;

endpackage

//--- logic/alu_ctrl_pkg.sv
package alu_ctrl_pkg;

    import alu_data_pkg::*;

    // operation codes seen by the execute stage
    typedef enum logic [7:0] {
        OP_NOP   = 8'h00,
        OP_AND   = 8'h01,
        OP_OR    = 8'h02,
        OP_NOR   = 8'h03,
        OP_XOR   = 8'h04,
        OP_ADD   = 8'h05,
        OP_ADDU  = 8'h06,
        OP_SUB   = 8'h07,
        OP_SUBU  = 8'h08,
        OP_SLT   = 8'h09,
        OP_SLTU  = 8'h0a,
        OP_SLLV  = 8'h0b,
        OP_SRLV  = 8'h0c,
        OP_SRAV  = 8'h0d,
        OP_SLL   = 8'h0e,
        OP_SRL   = 8'h0f,
        OP_SRA   = 8'h10,
        OP_LUI   = 8'h11,
        OP_CLO   = 8'h12,
        OP_CLZ   = 8'h13,
        OP_MOVN  = 8'h14,
        OP_MOVZ  = 8'h15,
        OP_MFHI  = 8'h16,
        OP_MFLO  = 8'h17,
        OP_MTHI  = 8'h18,
        OP_MTLO  = 8'h19,
        // multiply class
        OP_MULT  = 8'h20,
        OP_MULTU = 8'h21,
        OP_MUL   = 8'h22,
        OP_MADD  = 8'h23,
        OP_MADDU = 8'h24,
        OP_MSUB  = 8'h25,
        OP_MSUBU = 8'h26,
        // divide class
        OP_DIV   = 8'h30,
        OP_DIVU  = 8'h31
    } alu_op_e;

    typedef struct packed {
        alu_op_e         op;
        logic [XLEN-1:0] src_a;
        logic [XLEN-1:0] src_b;
        logic [4:0]      sa;
    } exec_req_t;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            overflow;
    } exec_rsp_t;

    // start is a level, held until the unit pulses ready
    typedef struct packed {
        logic            start;
        logic            is_signed;
        logic [XLEN-1:0] op_a;
        logic [XLEN-1:0] op_b;
    } muldiv_req_t;

endpackage

//--- logic/mul_unit.sv
module mul_unit
    import alu_ctrl_pkg::*;
    import alu_data_pkg::*;
#(
    parameter int MUL_STAGES = 4
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        flush_i,
    input  muldiv_req_t req_i,
    output logic        ready_o,
    output hilo_word_u  result_o
);

    if (MUL_STAGES < 1 || MUL_STAGES > 8) begin : g_stage_check
        $error("mul_unit: MUL_STAGES must be within 1 to 8");
    end

    logic            busy_q;
    logic [2:0]      cnt_q;
    logic            last;
    logic            capture;
    logic            neg_q;
    logic [XLEN-1:0] mag_a_q;
    logic [XLEN-1:0] mag_b_q;
    logic [2*XLEN-1:0] prod;

    assign capture = !busy_q && req_i.start && !flush_i;
    assign last    = busy_q && (cnt_q == 3'(MUL_STAGES - 1));
    assign ready_o = last && !flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (capture) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (last) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 3'd1;
        end
    end

    // operand magnitudes, sign restored on the way out
    always_ff @(posedge clk) begin
        if (capture) begin
            mag_a_q <= (req_i.is_signed && req_i.op_a[XLEN-1]) ? -req_i.op_a : req_i.op_a;
            mag_b_q <= (req_i.is_signed && req_i.op_b[XLEN-1]) ? -req_i.op_b : req_i.op_b;
            neg_q   <= req_i.is_signed && (req_i.op_a[XLEN-1] ^ req_i.op_b[XLEN-1]);
        end
    end

    assign prod          = mag_a_q * mag_b_q;
    assign result_o.full = neg_q ? -prod : prod;

    a_ready_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        ready_o |=> !ready_o)
        else $error("mul_unit: ready_o high on two consecutive cycles");

    // the core must keep requesting while the product is in flight
    a_start_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        (busy_q && !ready_o && !flush_i) |-> req_i.start)
        else $error("mul_unit: start dropped before ready");

endmodule

//--- logic/div_unit.sv
module div_unit
    import alu_ctrl_pkg::*;
    import alu_data_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        flush_i,
    input  muldiv_req_t req_i,
    output logic        ready_o,
    output hilo_word_u  result_o
);

    // one quotient bit per cycle
    localparam int ITERS = XLEN;

    logic            busy_q;
    logic [5:0]      cnt_q;
    logic            done;
    logic            capture;
    logic            q_neg_q;
    logic            r_neg_q;
    logic [XLEN-1:0] divisor_q;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] abs_a;
    logic [XLEN-1:0] abs_b;
    logic [XLEN:0]   trial;

    assign capture = !busy_q && req_i.start && !flush_i;
    assign done    = busy_q && (cnt_q == 6'(ITERS));
    assign ready_o = done && !flush_i;

    assign abs_a = (req_i.is_signed && req_i.op_a[XLEN-1]) ? -req_i.op_a : req_i.op_a;
    assign abs_b = (req_i.is_signed && req_i.op_b[XLEN-1]) ? -req_i.op_b : req_i.op_b;

    // shifted partial remainder minus divisor, msb set means restore
    assign trial = {rem_q, quo_q[XLEN-1]} - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (capture) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (done) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 6'd1;
        end
    end

    // quo_q starts as the dividend and fills with quotient bits
    always_ff @(posedge clk) begin
        if (capture) begin
            divisor_q <= abs_b;
            quo_q     <= abs_a;
            rem_q     <= '0;
            q_neg_q   <= req_i.is_signed && (req_i.op_a[XLEN-1] ^ req_i.op_b[XLEN-1]);
            r_neg_q   <= req_i.is_signed && req_i.op_a[XLEN-1];
        end else if (busy_q && !done) begin
            if (!trial[XLEN]) begin
                rem_q <= trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[XLEN-2:0], quo_q[XLEN-1]};
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // zero divisor falls out as all-ones quotient, dividend as remainder
    always_comb begin
        result_o.half.hi = r_neg_q ? -rem_q : rem_q;
        result_o.half.lo = q_neg_q ? -quo_q : quo_q;
    end

    a_ready_after_start: assert property (@(posedge clk) disable iff (!rst_n_i)
        ready_o |-> $past(req_i.start))
        else $error("div_unit: ready_o without a preceding start");

endmodule

//--- logic/hilo_reg.sv
module hilo_reg
    import alu_data_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  hilo_wr_t   wr_i,
    output hilo_word_u hilo_o
);

    hilo_word_u hilo_q;

    // halves update independently
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hilo_q.full <= '0;
        end else begin
            if (wr_i.hi_we) begin
                hilo_q.half.hi <= wr_i.data.half.hi;
            end
            if (wr_i.lo_we) begin
                hilo_q.half.lo <= wr_i.data.half.lo;
            end
        end
    end

    assign hilo_o = hilo_q;

    // an X enable from the core would corrupt architectural state silently
    a_we_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown({wr_i.hi_we, wr_i.lo_we}))
        else $error("hilo_reg: unknown write enable");

endmodule

//--- logic/alu_core.sv
module alu_core
    import alu_ctrl_pkg::*;
    import alu_data_pkg::*;
(
    input  exec_req_t   req_i,
    input  logic        flush_exc_i,
    input  hilo_word_u  hilo_i,
    input  logic        mul_ready_i,
    input  hilo_word_u  mul_result_i,
    input  logic        div_ready_i,
    input  hilo_word_u  div_result_i,
    output muldiv_req_t mul_req_o,
    output muldiv_req_t div_req_o,
    output hilo_wr_t    hilo_wr_o,
    output exec_rsp_t   rsp_o,
    output logic        stall_o
);

    logic            is_mul;
    logic            is_div;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            hi_we;
    logic            lo_we;
    hilo_word_u      wr_data;

    // number of zero bits above the first one, XLEN when all zero
    function automatic logic [XLEN-1:0] lead_zeros(input logic [XLEN-1:0] x);
        logic [XLEN-1:0] n;
        logic            found;
        n     = '0;
        found = 1'b0;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (x[i]) begin
                found = 1'b1;
            end else if (!found) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign a    = req_i.src_a;
    assign b    = req_i.src_b;
    assign sum  = a + b;
    assign diff = a - b;

    assign is_mul = req_i.op inside {OP_MULT, OP_MULTU, OP_MUL, OP_MADD, OP_MADDU,
                                     OP_MSUB, OP_MSUBU};
    assign is_div = req_i.op inside {OP_DIV, OP_DIVU};

    // start held until the unit answers, dropped in the ready cycle
    assign mul_req_o.start     = is_mul && !mul_ready_i;
    assign mul_req_o.is_signed = req_i.op inside {OP_MULT, OP_MUL, OP_MADD, OP_MSUB};
    assign mul_req_o.op_a      = a;
    assign mul_req_o.op_b      = b;

    assign div_req_o.start     = is_div && !div_ready_i;
    assign div_req_o.is_signed = (req_i.op == OP_DIV);
    assign div_req_o.op_a      = a;
    assign div_req_o.op_b      = b;

    assign stall_o = mul_req_o.start || div_req_o.start;

    always_comb begin
        rsp_o.result   = '0;
        rsp_o.overflow = 1'b0;
        case (req_i.op)
            OP_NOP:  rsp_o.result = a;
            OP_AND:  rsp_o.result = a & b;
            OP_OR:   rsp_o.result = a | b;
            OP_NOR:  rsp_o.result = ~(a | b);
            OP_XOR:  rsp_o.result = a ^ b;
            OP_ADD: begin
                rsp_o.result   = sum;
                rsp_o.overflow = (a[XLEN-1] == b[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);
            end
            OP_ADDU: rsp_o.result = sum;
            OP_SUB: begin
                rsp_o.result   = diff;
                rsp_o.overflow = (a[XLEN-1] != b[XLEN-1]) && (diff[XLEN-1] != a[XLEN-1]);
            end
            OP_SUBU: rsp_o.result = diff;
            OP_SLT:  rsp_o.result = XLEN'($signed(a) < $signed(b));
            OP_SLTU: rsp_o.result = XLEN'(a < b);
            // variable shifts take the amount from src_a
            OP_SLLV: rsp_o.result = b << a[4:0];
            OP_SRLV: rsp_o.result = b >> a[4:0];
            OP_SRAV: rsp_o.result = $signed(b) >>> a[4:0];
            OP_SLL:  rsp_o.result = b << req_i.sa;
            OP_SRL:  rsp_o.result = b >> req_i.sa;
            OP_SRA:  rsp_o.result = $signed(b) >>> req_i.sa;
            OP_LUI:  rsp_o.result = {b[15:0], 16'h0000};
            OP_CLO:  rsp_o.result = lead_zeros(~a);
            OP_CLZ:  rsp_o.result = lead_zeros(a);
            OP_MOVN: rsp_o.result = (b != '0) ? a : '0;
            OP_MOVZ: rsp_o.result = (b == '0) ? a : '0;
            OP_MFHI: rsp_o.result = hilo_i.half.hi;
            OP_MFLO: rsp_o.result = hilo_i.half.lo;
            // only the low word, HI/LO untouched
            OP_MUL: begin
                if (mul_ready_i) begin
                    rsp_o.result = mul_result_i.half.lo;
                end
            end
            default: rsp_o.result = '0;
        endcase
    end

    always_comb begin
        hi_we        = 1'b0;
        lo_we        = 1'b0;
        wr_data.full = mul_result_i.full;
        case (req_i.op)
            OP_MULT, OP_MULTU: begin
                hi_we = mul_ready_i;
                lo_we = mul_ready_i;
            end
            OP_MADD, OP_MADDU: begin
                hi_we        = mul_ready_i;
                lo_we        = mul_ready_i;
                wr_data.full = hilo_i.full + mul_result_i.full;
            end
            OP_MSUB, OP_MSUBU: begin
                hi_we        = mul_ready_i;
                lo_we        = mul_ready_i;
                wr_data.full = hilo_i.full - mul_result_i.full;
            end
            // remainder to HI, quotient to LO
            OP_DIV, OP_DIVU: begin
                hi_we        = div_ready_i;
                lo_we        = div_ready_i;
                wr_data.full = div_result_i.full;
            end
            OP_MTHI: begin
                hi_we           = 1'b1;
                wr_data.half.hi = a;
                wr_data.half.lo = hilo_i.half.lo;
            end
            OP_MTLO: begin
                lo_we           = 1'b1;
                wr_data.half.hi = hilo_i.half.hi;
                wr_data.half.lo = a;
            end
            default: ;
        endcase
    end

    // exception flush cancels the write but not the result
    assign hilo_wr_o.hi_we = hi_we && !flush_exc_i;
    assign hilo_wr_o.lo_we = lo_we && !flush_exc_i;
    assign hilo_wr_o.data  = wr_data;

endmodule

//--- logic/exec_unit.sv
module exec_unit
    import alu_ctrl_pkg::*;
    import alu_data_pkg::*;
#(
    parameter int MUL_STAGES = 4
) (
    input  logic      clk,
    input  logic      rst_n_i,
    input  exec_req_t req_i,
    input  logic      flush_i,
    input  logic      flush_exc_i,
    output exec_rsp_t rsp_o,
    output logic      stall_o
);

    muldiv_req_t mul_req;
    muldiv_req_t div_req;
    logic        mul_ready;
    logic        div_ready;
    hilo_word_u  mul_result;
    hilo_word_u  div_result;
    hilo_wr_t    hilo_wr;
    hilo_word_u  hilo_q;

    alu_core u_core (
        .req_i        (req_i),
        .flush_exc_i  (flush_exc_i),
        .hilo_i       (hilo_q),
        .mul_ready_i  (mul_ready),
        .mul_result_i (mul_result),
        .div_ready_i  (div_ready),
        .div_result_i (div_result),
        .mul_req_o    (mul_req),
        .div_req_o    (div_req),
        .hilo_wr_o    (hilo_wr),
        .rsp_o        (rsp_o),
        .stall_o      (stall_o)
    );

    mul_unit #(
        .MUL_STAGES (MUL_STAGES)
    ) u_mul (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .req_i    (mul_req),
        .ready_o  (mul_ready),
        .result_o (mul_result)
    );

    div_unit u_div (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .req_i    (div_req),
        .ready_o  (div_ready),
        .result_o (div_result)
    );

    hilo_reg u_hilo (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wr_i    (hilo_wr),
        .hilo_o  (hilo_q)
    );

endmodule

//--- tb/exec_ref_pkg.sv
package exec_ref_pkg;

    import alu_ctrl_pkg::*;

    // zero bits above the first one, 32 for a zero word
    function automatic int count_lead_zeros(input logic [31:0] x);
        int n;
        n = 0;
        while (n < 32 && x[31-n] == 1'b0) begin
            n++;
        end
        return n;
    endfunction

    // remainder in the upper word, quotient in the lower word
    function automatic logic [63:0] divide_pair(input logic [31:0] a, input logic [31:0] b,
                                                input logic signed_mode);
        logic        neg_a;
        logic        neg_b;
        logic [31:0] mag_a;
        logic [31:0] mag_b;
        logic [31:0] quo;
        logic [31:0] rem;
        neg_a = signed_mode && a[31];
        neg_b = signed_mode && b[31];
        mag_a = neg_a ? 32'h0 - a : a;
        mag_b = neg_b ? 32'h0 - b : b;
        if (mag_b == 32'h0) begin
            quo = 32'hffff_ffff;
            rem = mag_a;
        end else begin
            quo = mag_a / mag_b;
            rem = mag_a % mag_b;
        end
        // quotient sign from both operands, remainder follows the dividend
        if (neg_a ^ neg_b) begin
            quo = 32'h0 - quo;
        end
        if (neg_a) begin
            rem = 32'h0 - rem;
        end
        return {rem, quo};
    endfunction

    function automatic logic [31:0] expected_result(input alu_op_e op, input logic [31:0] a,
                                                    input logic [31:0] b, input logic [4:0] sa,
                                                    input logic [63:0] hilo);
        longint prod;
        prod = longint'(int'(a)) * longint'(int'(b));
        case (op)
            OP_NOP:           return a;
            OP_AND:           return a & b;
            OP_OR:            return a | b;
            OP_NOR:           return ~(a | b);
            OP_XOR:           return a ^ b;
            OP_ADD, OP_ADDU:  return a + b;
            OP_SUB, OP_SUBU:  return a - b;
            OP_SLT:           return (int'(a) < int'(b)) ? 32'd1 : 32'd0;
            OP_SLTU:          return (a < b) ? 32'd1 : 32'd0;
            OP_SLLV:          return b << a[4:0];
            OP_SRLV:          return b >> a[4:0];
            OP_SRAV:          return int'(b) >>> a[4:0];
            OP_SLL:           return b << sa;
            OP_SRL:           return b >> sa;
            OP_SRA:           return int'(b) >>> sa;
            OP_LUI:           return {b[15:0], 16'h0000};
            OP_CLO:           return count_lead_zeros(~a);
            OP_CLZ:           return count_lead_zeros(a);
            OP_MOVN:          return (b != 32'h0) ? a : 32'h0;
            OP_MOVZ:          return (b == 32'h0) ? a : 32'h0;
            OP_MFHI:          return hilo[63:32];
            OP_MFLO:          return hilo[31:0];
            OP_MUL:           return prod[31:0];
            default:          return 32'h0;
        endcase
    endfunction

    // overflow when the exact sum does not fit in 32 signed bits
    function automatic logic expected_overflow(input alu_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
        longint s;
        case (op)
            OP_ADD:  s = longint'(int'(a)) + longint'(int'(b));
            OP_SUB:  s = longint'(int'(a)) - longint'(int'(b));
            default: return 1'b0;
        endcase
        return s != longint'(int'(s[31:0]));
    endfunction

    function automatic logic [63:0] expected_hilo(input alu_op_e op, input logic [31:0] a,
                                                  input logic [31:0] b, input logic [63:0] hilo);
        logic [63:0] sprod;
        logic [63:0] uprod;
        sprod = longint'(int'(a)) * longint'(int'(b));
        uprod = {32'h0, a} * {32'h0, b};
        case (op)
            OP_MULT:  return sprod;
            OP_MULTU: return uprod;
            OP_MADD:  return hilo + sprod;
            OP_MADDU: return hilo + uprod;
            OP_MSUB:  return hilo - sprod;
            OP_MSUBU: return hilo - uprod;
            OP_DIV:   return divide_pair(a, b, 1'b1);
            OP_DIVU:  return divide_pair(a, b, 1'b0);
            OP_MTHI:  return {a, hilo[31:0]};
            OP_MTLO:  return {hilo[63:32], a};
            default:  return hilo;
        endcase
    endfunction

    // cycles from the first request cycle up to and including the last one
    function automatic int expected_cycles(input alu_op_e op, input int mul_stages);
        if (op inside {OP_MULT, OP_MULTU, OP_MUL, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU}) begin
            return mul_stages + 1;
        end
        if (op inside {OP_DIV, OP_DIVU}) begin
            return 34;
        end
        return 1;
    endfunction

endpackage

//--- tb/tb_exec_unit.sv
module tb_exec_unit
    import alu_ctrl_pkg::*;
    import exec_ref_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MUL_STAGES  = 4;
    localparam int HALF_PERIOD = 10;
    localparam int N_RANDOM    = 300;
    localparam int N_MOVES     = 4;
    localparam int N_MUL       = 12;
    localparam int N_ACC       = 4;
    localparam int N_DIR       = 8;
    localparam int N_DIV       = 10;
    // reset reads and the flush section account for the constant part
    localparam int N_OPS = 17 + N_RANDOM + 6 * N_MOVES + 7 * N_MUL + 14 * N_ACC
                         + 6 * (N_DIR + N_DIV);
    localparam int CYCLE_LIMIT = N_OPS * (33 + MUL_STAGES + 2) + 100;

    logic        clk;
    logic        rst_n;
    exec_req_t   req;
    logic        flush;
    logic        flush_exc;
    exec_rsp_t   rsp;
    logic        stall;

    exec_rsp_t   exp_rsp;
    logic        exp_valid;
    logic [63:0] hilo_model;
    int          n_errors;
    int          n_checks;
    int          cycle_cnt;
    integer      seed;

    alu_op_e single_ops [26] = '{OP_NOP, OP_AND, OP_OR, OP_NOR, OP_XOR, OP_ADD, OP_ADDU,
                                 OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_SLLV, OP_SRLV, OP_SRAV,
                                 OP_SLL, OP_SRL, OP_SRA, OP_LUI, OP_CLO, OP_CLZ, OP_MOVN,
                                 OP_MOVZ, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO};
    alu_op_e acc_ops [4] = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};

    // zero divisors, most negative by -1 and negative dividends
    logic [31:0] div_dividend [N_DIR] = '{32'd100, 32'hffff_fff9, 32'd7, 32'hffff_fff9,
                                          32'h8000_0000, 32'd12345, 32'hffff_fffb,
                                          32'h8000_0000};
    logic [31:0] div_divisor [N_DIR] = '{32'd7, 32'd2, 32'hffff_fffe, 32'hffff_fffe,
                                         32'hffff_ffff, 32'd0, 32'd0, 32'd0};

    exec_unit #(
        .MUL_STAGES (MUL_STAGES)
    ) i_dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .req_i       (req),
        .flush_i     (flush),
        .flush_exc_i (flush_exc),
        .rsp_o       (rsp),
        .stall_o     (stall)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // corner values mixed into the random operands
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h8000_0000;
            3'd3:    return 32'h7fff_ffff;
            default: return $random(seed);
        endcase
    endfunction

    // one operation, held until stall_o drops, then the model takes the write
    task automatic run_op(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                          input logic [4:0] sa, input logic exc);
        int cycles;
        @(negedge clk);
        req.op           = op;
        req.src_a        = a;
        req.src_b        = b;
        req.sa           = sa;
        flush            = 1'b0;
        flush_exc        = exc;
        exp_rsp.result   = expected_result(op, a, b, sa, hilo_model);
        exp_rsp.overflow = expected_overflow(op, a, b);
        exp_valid        = 1'b1;
        cycles           = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (stall);
        check_value("stall_o cycles", cycles, expected_cycles(op, MUL_STAGES));
        if (!exc) begin
            hilo_model = expected_hilo(op, a, b, hilo_model);
        end
    endtask

    task automatic read_hilo();
        run_op(OP_MFHI, 32'h0, 32'h0, 5'd0, 1'b0);
        run_op(OP_MFLO, 32'h0, 32'h0, 5'd0, 1'b0);
    endtask

    // start a long operation and kill it with flush_i after some cycles
    task automatic abort_op(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                            input int hold);
        @(negedge clk);
        req.op    = op;
        req.src_a = a;
        req.src_b = b;
        req.sa    = 5'd0;
        flush     = 1'b0;
        flush_exc = 1'b0;
        exp_valid = 1'b0;
        repeat (hold) begin
            @(posedge clk);
            check_value("stall_o", stall, 1'b1);
        end
        @(negedge clk);
        flush = 1'b1;
        @(posedge clk);
    endtask

    // response compare whenever the stage is not stalled
    always @(posedge clk) begin
        if (rst_n && exp_valid && !stall) begin
            check_value("rsp_o.result", rsp.result, exp_rsp.result);
            check_value("rsp_o.overflow", rsp.overflow, exp_rsp.overflow);
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: operations did not complete");
        $display("checks %0d, errors %0d", n_checks, n_errors);
        $display("tests failed");
        $finish;
    end

    initial begin
        alu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        seed       = 32'hd0635495;
        n_errors   = 0;
        n_checks   = 0;
        hilo_model = '0;
        exp_valid  = 1'b0;
        exp_rsp    = '0;
        req        = '0;
        flush      = 1'b0;
        flush_exc  = 1'b0;
        rst_n      = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle and cleared right after reset
        @(posedge clk);
        check_value("stall_o", stall, 1'b0);
        read_hilo();

        for (int i = 0; i < N_RANDOM; i++) begin
            op = single_ops[$unsigned($random(seed)) % 26];
            a  = pick_operand();
            b  = pick_operand();
            run_op(op, a, b, 5'($random(seed)), 1'b0);
        end

        for (int i = 0; i < N_MOVES; i++) begin
            a = $random(seed);
            run_op(OP_MTHI, a, 32'h0, 5'd0, 1'b0);
            read_hilo();
            a = $random(seed);
            run_op(OP_MTLO, a, 32'h0, 5'd0, 1'b0);
            read_hilo();
        end

        for (int i = 0; i < N_MUL; i++) begin
            a = pick_operand();
            b = pick_operand();
            run_op(OP_MULT, a, b, 5'd0, 1'b0);
            read_hilo();
            run_op(OP_MULTU, a, b, 5'd0, 1'b0);
            read_hilo();
            run_op(OP_MUL, a, b, 5'd0, 1'b0);
        end

        // accumulate chains on a preset HI/LO
        for (int i = 0; i < N_ACC; i++) begin
            a = pick_operand();
            run_op(OP_MTHI, a, 32'h0, 5'd0, 1'b0);
            a = pick_operand();
            run_op(OP_MTLO, a, 32'h0, 5'd0, 1'b0);
            for (int k = 0; k < 4; k++) begin
                a = pick_operand();
                b = pick_operand();
                run_op(acc_ops[k], a, b, 5'd0, 1'b0);
                read_hilo();
            end
        end

        for (int i = 0; i < N_DIR + N_DIV; i++) begin
            if (i < N_DIR) begin
                a = div_dividend[i];
                b = div_divisor[i];
            end else begin
                a = $random(seed);
                b = $random(seed);
                b = b >> (i % 29);
            end
            run_op(OP_DIV, a, b, 5'd0, 1'b0);
            read_hilo();
            run_op(OP_DIVU, a, b, 5'd0, 1'b0);
            read_hilo();
        end

        // aborted multiply, then a clean one while the old product would still be due
        abort_op(OP_MULT, 32'h1234_5678, 32'h9abc_def0, 2);
        run_op(OP_NOP, 32'h5a5a_5a5a, 32'h0, 5'd0, 1'b0);
        run_op(OP_MULT, 32'hffff_fff3, 32'h0000_0011, 5'd0, 1'b0);
        read_hilo();

        abort_op(OP_DIV, 32'h0001_0000, 32'h0000_0003, 10);
        run_op(OP_NOP, 32'ha5a5_a5a5, 32'h0, 5'd0, 1'b0);
        read_hilo();
        run_op(OP_DIVU, 32'h0001_0000, 32'h0000_0003, 5'd0, 1'b0);
        read_hilo();

        // exception flush drops the HI write
        run_op(OP_MTHI, 32'hdead_beef, 32'h0, 5'd0, 1'b1);
        read_hilo();

        @(negedge clk);
        exp_valid = 1'b0;
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- flist.f
logic/alu_data_pkg.sv
logic/alu_ctrl_pkg.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/hilo_reg.sv
logic/alu_core.sv
logic/exec_unit.sv
tb/exec_ref_pkg.sv
tb/tb_exec_unit.sv

//--- Bender.yml
package:
  name: exec_unit

sources:
  - logic/alu_data_pkg.sv
  - logic/alu_ctrl_pkg.sv
  - logic/mul_unit.sv
  - logic/div_unit.sv
  - logic/hilo_reg.sv
  - logic/alu_core.sv
  - logic/exec_unit.sv
  - target: test
    files:
      - tb/exec_ref_pkg.sv
      - tb/tb_exec_unit.sv
